/* verilog.f */
source/core_pkg.sv
source/core_ifu.sv
source/core_ibuf.sv
source/core_idu.sv
source/core_regfile.sv
source/core_exu.sv
source/core_top.sv
verification/core_tb.sv

/* Bender.yml */
package:
  name: core

sources:
  - source/core_pkg.sv
  - source/core_ifu.sv
  - source/core_ibuf.sv
  - source/core_idu.sv
  - source/core_regfile.sv
  - source/core_exu.sv
  - source/core_top.sv
  - target: test
    files:
      - verification/core_tb.sv

/* verification/core_tb.sv */
module core_tb import core_pkg::*; ();

    localparam int MEM_WORDS = 64;
    localparam logic [31:0] LFSR_SEED = 32'h56d3647c;

    logic        clock;
    logic        rst_n;
    logic        arvalid;
    logic        arready = 1'b0;
    logic [31:0] araddr;
    logic [2:0]  arprot;
    logic        rvalid = 1'b0;
    logic        rready;
    logic [31:0] rdata = '0;
    logic [1:0]  rresp = 2'b00;
    logic        retire_valid;
    logic [31:0] retire_pc;
    logic        retire_wen;
    logic [4:0]  retire_rd;
    logic [31:0] retire_data;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] ref_regs [32];
    logic [31:0] lfsr_q = LFSR_SEED;

    // expected retire stream in program order
    logic [31:0] exp_pc [$];
    logic        exp_wen [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];

    int          ret_count;
    int          mismatches;
    int          failures;
    int          cycles;
    int          limit;

    // memory model state
    logic [1:0]  ar_wait;
    logic [1:0]  r_wait;
    logic        r_pending;
    logic [31:0] rd_addr;
    logic        ar_waiting;
    logic [31:0] ar_addr_seen;

    core_top i_dut (
        .clock          ( clock        ),
        .rst_n_i        ( rst_n        ),
        .m_arvalid_o    ( arvalid      ),
        .m_arready_i    ( arready      ),
        .m_araddr_o     ( araddr       ),
        .m_arprot_o     ( arprot       ),
        .m_rvalid_i     ( rvalid       ),
        .m_rready_o     ( rready       ),
        .m_rdata_i      ( rdata        ),
        .m_rresp_i      ( rresp        ),
        .retire_valid_o ( retire_valid ),
        .retire_pc_o    ( retire_pc    ),
        .retire_wen_o   ( retire_wen   ),
        .retire_rd_o    ( retire_rd    ),
        .retire_data_o  ( retire_data  )
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    function automatic logic [31:0] rr_inst(input int f7, input int f3, input int rd,
                                            input int rs1, input int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] imm_inst(input int f3, input int rd, input int rs1,
                                             input int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'h13};
    endfunction

    function automatic logic [31:0] lui_inst(input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], 7'h37};
    endfunction

    function automatic logic [31:0] branch_inst(input int f3, input int rs1, input int rs2,
                                                input int off);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63};
    endfunction

    function automatic logic [31:0] jal_inst(input int rd, input int off);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f};
    endfunction

    // galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [1:0] rand_delay();
        logic [1:0] d;
        d = '0;
        for (int i = 0; i < 2; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            d = {d[0], lfsr_q[0]};
        end
        return d;
    endfunction

    task automatic load_memory();
        // unused words are ADDI x0,x0,index
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = imm_inst(0, 0, 0, i);
        end
        mem[0]  = imm_inst(0, 1, 0, 5);
        mem[1]  = imm_inst(0, 2, 0, -3);
        mem[2]  = rr_inst(7'h00, 0, 3, 1, 2);
        mem[3]  = rr_inst(7'h20, 0, 4, 2, 1);
        mem[4]  = rr_inst(7'h00, 2, 5, 2, 1);
        mem[5]  = rr_inst(7'h00, 2, 6, 1, 2);
        mem[6]  = rr_inst(7'h00, 1, 7, 1, 1);
        mem[7]  = rr_inst(7'h00, 5, 8, 2, 1);
        mem[8]  = rr_inst(7'h00, 7, 9, 1, 2);
        mem[9]  = rr_inst(7'h00, 6, 10, 1, 2);
        mem[10] = rr_inst(7'h00, 4, 11, 1, 2);
        mem[11] = lui_inst(12, 20'habcde);
        mem[12] = imm_inst(6, 12, 12, 12'h123);
        mem[13] = imm_inst(4, 13, 12, -1);
        mem[14] = imm_inst(7, 14, 13, 12'h0ff);
        mem[15] = imm_inst(2, 15, 2, -2);
        // x0 as destination and then read back
        mem[16] = imm_inst(0, 0, 1, 7);
        mem[17] = rr_inst(7'h00, 0, 16, 0, 1);
        mem[18] = branch_inst(0, 1, 2, 8);
        mem[19] = branch_inst(1, 1, 2, 8);
        mem[20] = imm_inst(0, 17, 0, 99);
        mem[21] = branch_inst(0, 3, 3, 12);
        mem[22] = imm_inst(0, 18, 0, 1);
        mem[23] = imm_inst(0, 18, 0, 2);
        mem[24] = branch_inst(1, 5, 5, 8);
        mem[25] = jal_inst(19, 12);
        mem[26] = imm_inst(0, 20, 0, 1);
        mem[27] = imm_inst(0, 20, 0, 2);
        mem[28] = rr_inst(7'h00, 0, 21, 19, 1);
        mem[29] = jal_inst(0, 8);
        mem[30] = imm_inst(0, 22, 0, 1);
        mem[31] = lui_inst(0, 20'h12345);
        mem[32] = imm_inst(0, 23, 0, 0);
        // three pass loop on x24
        mem[33] = imm_inst(0, 24, 24, 1);
        mem[34] = imm_inst(0, 25, 0, 3);
        mem[35] = branch_inst(1, 24, 25, -8);
        mem[36] = rr_inst(7'h20, 0, 26, 0, 24);
        mem[37] = rr_inst(7'h00, 5, 27, 26, 24);
        mem[38] = rr_inst(7'h00, 1, 28, 26, 24);
        mem[39] = jal_inst(0, 0);
    endtask

    // ISA model of one instruction
    function automatic void ref_exec(input logic [31:0] inst, input logic [31:0] pc,
                                     output logic [31:0] next_pc, output logic wen,
                                     output logic [4:0] rd, output logic [31:0] data);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [2:0]  f3;
        logic [6:0]  f7;
        a = ref_regs[inst[19:15]];
        b = ref_regs[inst[24:20]];
        imm = {{20{inst[31]}}, inst[31:20]};
        f3 = inst[14:12];
        f7 = inst[31:25];
        next_pc = pc + 32'd4;
        wen = 1'b0;
        rd = inst[11:7];
        data = '0;
        case (inst[6:0])
            7'h33: begin
                if (f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'd0)) begin
                    wen = (f3 != 3'd3);
                    case (f3)
                        3'd0: data = f7[5] ? a - b : a + b;
                        3'd1: data = a << b[4:0];
                        3'd2: data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        3'd4: data = a ^ b;
                        3'd5: data = a >> b[4:0];
                        3'd6: data = a | b;
                        3'd7: data = a & b;
                        default: data = '0;
                    endcase
                end
            end
            7'h13: begin
                wen = 1'b1;
                case (f3)
                    3'd0: data = a + imm;
                    3'd2: data = ($signed(a) < $signed(imm)) ? 32'd1 : 32'd0;
                    3'd4: data = a ^ imm;
                    3'd6: data = a | imm;
                    3'd7: data = a & imm;
                    default: wen = 1'b0;
                endcase
            end
            7'h37: begin
                wen = 1'b1;
                data = {inst[31:12], 12'h000};
            end
            7'h63: begin
                imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
                if ((f3 == 3'd0 && a == b) || (f3 == 3'd1 && a != b)) begin
                    next_pc = pc + imm;
                end
            end
            7'h6f: begin
                imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
                wen = 1'b1;
                data = pc + 32'd4;
                next_pc = pc + imm;
            end
            default: ;
        endcase
        if (rd == 5'd0) begin
            wen = 1'b0;
        end
        if (wen) begin
            ref_regs[rd] = data;
        end
    endfunction

    task automatic add_expected(input logic [31:0] pc, input logic wen, input logic [4:0] rd,
                                input logic [31:0] data);
        exp_pc.push_back(pc);
        exp_wen.push_back(wen);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
    endtask

    task automatic build_expected();
        logic [31:0] pc;
        logic [31:0] next_pc;
        logic        wen;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        looped;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        pc = RESET_PC;
        looped = 1'b0;
        steps = 0;
        while (!looped && steps < 200) begin
            ref_exec(mem[pc[7:2]], pc, next_pc, wen, rd, data);
            add_expected(pc, wen, rd, data);
            looped = (next_pc == pc);
            pc = next_pc;
            steps++;
        end
        // core keeps spinning on the final jump
        repeat (5) add_expected(pc, 1'b0, 5'd0, pc + 32'd4);
    endtask

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            $display("ERROR %s expected %h actual %h", name, exp_v, act_v);
            mismatches++;
        end
    endtask

    // AXI4-Lite read slave with random ready and valid delays
    always @(posedge clock) begin
        if (!rst_n) begin
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            r_pending <= 1'b0;
            ar_wait   <= 2'd0;
            r_wait    <= 2'd0;
        end else begin
            if (arready && arvalid) begin
                arready   <= 1'b0;
                rd_addr   <= araddr;
                r_pending <= 1'b1;
                r_wait    <= rand_delay();
                ar_wait   <= rand_delay();
            end else if (arvalid && !arready) begin
                if (ar_wait == 2'd0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 2'd1;
                end
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end else if (r_pending && !rvalid) begin
                if (r_wait == 2'd0) begin
                    rvalid    <= 1'b1;
                    rdata     <= mem[rd_addr[7:2]];
                    r_pending <= 1'b0;
                end else begin
                    r_wait <= r_wait - 2'd1;
                end
            end
        end
    end

    // AR payload has to hold until accepted
    always @(posedge clock) begin
        if (!rst_n) begin
            ar_waiting <= 1'b0;
        end else begin
            if (ar_waiting) begin
                assert (arvalid) else begin
                    $display("AR valid was withdrawn before the handshake");
                    failures++;
                end
                check_value("m_araddr_o", ar_addr_seen, araddr);
            end
            // prot bit 2 marks an instruction fetch
            if (arvalid) begin
                check_value("m_arprot_o[2]", 32'd1, {31'b0, arprot[2]});
            end
            ar_waiting   <= arvalid && !arready;
            ar_addr_seen <= araddr;
        end
    end

    always @(posedge clock) begin
        if (rst_n && retire_valid && ret_count < exp_pc.size()) begin
            check_value("retire_pc_o", exp_pc[ret_count], retire_pc);
            check_value("retire_wen_o", {31'b0, exp_wen[ret_count]}, {31'b0, retire_wen});
            if (exp_wen[ret_count]) begin
                check_value("retire_rd_o", {27'b0, exp_rd[ret_count]}, {27'b0, retire_rd});
                check_value("retire_data_o", exp_data[ret_count], retire_data);
            end
            ret_count++;
        end
    end

    initial begin
        rst_n = 1'b0;
        ret_count = 0;
        mismatches = 0;
        failures = 0;
        load_memory();
        build_expected();
        limit = 60 * exp_pc.size();
        repeat (8) @(posedge clock);
        rst_n <= 1'b1;
        @(posedge clock);
        assert (!arvalid && !rready && !retire_valid) else begin
            $display("bus or retire outputs were active right after reset");
            failures++;
        end
        @(posedge clock);
        assert (arvalid) else begin
            $display("first instruction fetch was not requested after reset");
            failures++;
        end
        check_value("m_araddr_o", RESET_PC, araddr);
        cycles = 2;
        while (ret_count < exp_pc.size() && cycles < limit) begin
            @(posedge clock);
            cycles++;
        end
        if (ret_count < exp_pc.size()) begin
            $display("timeout, the core stalled after %0d of %0d retires", ret_count,
                     exp_pc.size());
            failures++;
        end
        $display("retires %0d, mismatches %0d, other failures %0d", ret_count, mismatches,
                 failures);
        if (mismatches == 0 && failures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* source/core_top.sv */
module core_top import core_pkg::*; (
    input  logic            clock,
    input  logic            rst_n_i,
    output logic            m_arvalid_o,
    input  logic            m_arready_i,
    output logic [31:0]     m_araddr_o,
    output logic [2:0]      m_arprot_o,
    input  logic            m_rvalid_i,
    output logic            m_rready_o,
    input  logic [31:0]     m_rdata_i,
    input  logic [1:0]      m_rresp_i,
    output logic            retire_valid_o,
    output logic [31:0]     retire_pc_o,
    output logic            retire_wen_o,
    output logic [4:0]      retire_rd_o,
    output logic [31:0]     retire_data_o
);

    // fetch to queue
    logic            push_valid;
    logic            push_ready;
    logic [XLEN-1:0] push_inst;
    logic [XLEN-1:0] push_pc;

    // queue head
    logic            head_valid;
    logic [XLEN-1:0] head_inst;
    logic [XLEN-1:0] head_pc;
    logic            pop;

    logic            redirect_valid;
    logic [XLEN-1:0] redirect_pc;

    // decode
    logic [4:0]      idu_rs1;
    logic [4:0]      idu_rs2;
    logic [4:0]      idu_rd;
    logic [XLEN-1:0] idu_imm;
    alu_op_e         idu_alu_op;
    logic            idu_use_imm;
    logic            idu_rd_wen;
    logic            idu_branch;
    logic            idu_branch_ne;
    logic            idu_jal;

    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic            wb_wen;
    logic [4:0]      wb_addr;
    logic [XLEN-1:0] wb_data;

    core_ifu ifu_u0 (
        .clock            ( clock          ),
        .rst_n_i          ( rst_n_i        ),
        .m_arready_i      ( m_arready_i    ),
        .m_rvalid_i       ( m_rvalid_i     ),
        .m_rdata_i        ( m_rdata_i      ),
        .push_ready_i     ( push_ready     ),
        .redirect_valid_i ( redirect_valid ),
        .redirect_pc_i    ( redirect_pc    ),
        .m_arvalid_o      ( m_arvalid_o    ),
        .m_araddr_o       ( m_araddr_o     ),
        .m_arprot_o       ( m_arprot_o     ),
        .m_rready_o       ( m_rready_o     ),
        .push_valid_o     ( push_valid     ),
        .push_inst_o      ( push_inst      ),
        .push_pc_o        ( push_pc        )
    );

    core_ibuf ibuf_u0 (
        .clock            ( clock          ),
        .rst_n_i          ( rst_n_i        ),
        .flush_i          ( redirect_valid ),
        .push_valid_i     ( push_valid     ),
        .push_inst_i      ( push_inst      ),
        .push_pc_i        ( push_pc        ),
        .pop_i            ( pop            ),
        .push_ready_o     ( push_ready     ),
        .head_valid_o     ( head_valid     ),
        .head_inst_o      ( head_inst      ),
        .head_pc_o        ( head_pc        )
    );

    core_idu idu_u0 (
        .inst_i           ( head_inst      ),
        .rs1_o            ( idu_rs1        ),
        .rs2_o            ( idu_rs2        ),
        .rd_o             ( idu_rd         ),
        .imm_o            ( idu_imm        ),
        .alu_op_o         ( idu_alu_op     ),
        .use_imm_o        ( idu_use_imm    ),
        .rd_wen_o         ( idu_rd_wen     ),
        .branch_o         ( idu_branch     ),
        .branch_ne_o      ( idu_branch_ne  ),
        .jal_o            ( idu_jal        )
    );

    core_regfile regfile_u0 (
        .clock            ( clock          ),
        .rst_n_i          ( rst_n_i        ),
        .rs1_addr_i       ( idu_rs1        ),
        .rs2_addr_i       ( idu_rs2        ),
        .wen_i            ( wb_wen         ),
        .wd_addr_i        ( wb_addr        ),
        .wd_data_i        ( wb_data        ),
        .rs1_data_o       ( src1           ),
        .rs2_data_o       ( src2           )
    );

    core_exu exu_u0 (
        .clock            ( clock          ),
        .rst_n_i          ( rst_n_i        ),
        .head_valid_i     ( head_valid     ),
        .head_pc_i        ( head_pc        ),
        .rd_i             ( idu_rd         ),
        .imm_i            ( idu_imm        ),
        .alu_op_i         ( idu_alu_op     ),
        .use_imm_i        ( idu_use_imm    ),
        .rd_wen_i         ( idu_rd_wen     ),
        .branch_i         ( idu_branch     ),
        .branch_ne_i      ( idu_branch_ne  ),
        .jal_i            ( idu_jal        ),
        .rs1_data_i       ( src1           ),
        .rs2_data_i       ( src2           ),
        .pop_o            ( pop            ),
        .redirect_valid_o ( redirect_valid ),
        .redirect_pc_o    ( redirect_pc    ),
        .wb_wen_o         ( wb_wen         ),
        .wb_addr_o        ( wb_addr        ),
        .wb_data_o        ( wb_data        ),
        .retire_valid_o   ( retire_valid_o ),
        .retire_pc_o      ( retire_pc_o    ),
        .retire_wen_o     ( retire_wen_o   ),
        .retire_rd_o      ( retire_rd_o    ),
        .retire_data_o    ( retire_data_o  )
    );

endmodule

/* source/core_exu.sv */
module core_exu import core_pkg::*; (
    input  logic            clock,
    input  logic            rst_n_i,
    input  logic            head_valid_i,
    input  logic [31:0]     head_pc_i,
    input  logic [4:0]      rd_i,
    input  logic [31:0]     imm_i,
    input  alu_op_e         alu_op_i,
    input  logic            use_imm_i,
    input  logic            rd_wen_i,
    input  logic            branch_i,
    input  logic            branch_ne_i,
    input  logic            jal_i,
    input  logic [31:0]     rs1_data_i,
    input  logic [31:0]     rs2_data_i,
    output logic            pop_o,
    output logic            redirect_valid_o,
    output logic [31:0]     redirect_pc_o,
    output logic            wb_wen_o,
    output logic [4:0]      wb_addr_o,
    output logic [31:0]     wb_data_o,
    output logic            retire_valid_o,
    output logic [31:0]     retire_pc_o,
    output logic            retire_wen_o,
    output logic [4:0]      retire_rd_o,
    output logic [31:0]     retire_data_o
);

    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic            taken;

    assign op_b = use_imm_i ? imm_i : rs2_data_i;

    always_comb begin
        case (alu_op_i)
            ALU_SUB:    alu_res = rs1_data_i - op_b;
            ALU_AND:    alu_res = rs1_data_i & op_b;
            ALU_OR:     alu_res = rs1_data_i | op_b;
            ALU_XOR:    alu_res = rs1_data_i ^ op_b;
            ALU_SLT:    alu_res = {31'b0, $signed(rs1_data_i) < $signed(op_b)};
            ALU_SLL:    alu_res = rs1_data_i << op_b[4:0];
            ALU_SRL:    alu_res = rs1_data_i >> op_b[4:0];
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = rs1_data_i + op_b;
        endcase
    end

    // one instruction per cycle whenever the queue has one
    assign pop_o = head_valid_i;

    assign taken            = branch_i && ((rs1_data_i == rs2_data_i) != branch_ne_i);
    assign redirect_valid_o = head_valid_i && (taken || jal_i);
    assign redirect_pc_o    = head_pc_i + imm_i;

    assign wb_wen_o  = head_valid_i && rd_wen_i && (rd_i != 5'd0);
    assign wb_addr_o = rd_i;
    assign wb_data_o = jal_i ? head_pc_i + 32'd4 : alu_res;

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            retire_valid_o <= 1'b0;
            retire_wen_o   <= 1'b0;
        end else begin
            retire_valid_o <= pop_o;
            retire_wen_o   <= wb_wen_o;
        end
    end

    always_ff @(posedge clock) begin
        if (pop_o) begin
            retire_pc_o   <= head_pc_i;
            retire_rd_o   <= wb_addr_o;
            retire_data_o <= wb_data_o;
        end
    end

endmodule

/* source/core_regfile.sv */
module core_regfile import core_pkg::*; (
    input  logic            clock,
    input  logic            rst_n_i,
    input  logic [4:0]      rs1_addr_i,
    input  logic [4:0]      rs2_addr_i,
    input  logic            wen_i,
    input  logic [4:0]      wd_addr_i,
    input  logic [31:0]     wd_data_i,
    output logic [31:0]     rs1_data_o,
    output logic [31:0]     rs2_data_o
);

    // x0 has no storage
    logic [XLEN-1:0] regs_q [1:31];

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wen_i && wd_addr_i != 5'd0) begin
            regs_q[wd_addr_i] <= wd_data_i;
        end
    end

    assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs_q[rs2_addr_i];

endmodule

/* source/core_idu.sv */
module core_idu import core_pkg::*; (
    input  logic [31:0]     inst_i,
    output logic [4:0]      rs1_o,
    output logic [4:0]      rs2_o,
    output logic [4:0]      rd_o,
    output logic [31:0]     imm_o,
    output alu_op_e         alu_op_o,
    output logic            use_imm_o,
    output logic            rd_wen_o,
    output logic            branch_o,
    output logic            branch_ne_o,
    output logic            jal_o
);

    opcode_e         opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [XLEN-1:0] imm_i_type;
    logic [XLEN-1:0] imm_u_type;
    logic [XLEN-1:0] imm_b_type;
    logic [XLEN-1:0] imm_j_type;

    assign opcode = opcode_e'(inst_i[6:0]);
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign rs1_o = inst_i[19:15];
    assign rs2_o = inst_i[24:20];
    assign rd_o  = inst_i[11:7];

    assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u_type = {inst_i[31:12], 12'b0};
    assign imm_b_type = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                         inst_i[11:8], 1'b0};
    assign imm_j_type = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                         inst_i[30:21], 1'b0};

    always_comb begin
        imm_o       = imm_i_type;
        alu_op_o    = ALU_ADD;
        use_imm_o   = 1'b0;
        rd_wen_o    = 1'b0;
        branch_o    = 1'b0;
        branch_ne_o = 1'b0;
        jal_o       = 1'b0;
        case (opcode)
            OPC_OP: begin
                // only funct7 = 0, plus SUB with bit 30 set
                rd_wen_o = (funct7 == 7'b0000000) ||
                           (funct7 == 7'b0100000 && funct3 == 3'b000);
                case (funct3)
                    3'b000: alu_op_o = funct7[5] ? ALU_SUB : ALU_ADD;
                    3'b001: alu_op_o = ALU_SLL;
                    3'b010: alu_op_o = ALU_SLT;
                    3'b100: alu_op_o = ALU_XOR;
                    3'b101: alu_op_o = ALU_SRL;
                    3'b110: alu_op_o = ALU_OR;
                    3'b111: alu_op_o = ALU_AND;
                    default: rd_wen_o = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                use_imm_o = 1'b1;
                rd_wen_o  = 1'b1;
                case (funct3)
                    3'b000: alu_op_o = ALU_ADD;
                    3'b010: alu_op_o = ALU_SLT;
                    3'b100: alu_op_o = ALU_XOR;
                    3'b110: alu_op_o = ALU_OR;
                    3'b111: alu_op_o = ALU_AND;
                    default: rd_wen_o = 1'b0;
                endcase
            end
            OPC_LUI: begin
                imm_o     = imm_u_type;
                alu_op_o  = ALU_PASS_B;
                use_imm_o = 1'b1;
                rd_wen_o  = 1'b1;
            end
            OPC_BRANCH: begin
                imm_o       = imm_b_type;
                branch_o    = (funct3 == 3'b000) || (funct3 == 3'b001);
                branch_ne_o = (funct3 == 3'b001);
            end
            OPC_JAL: begin
                imm_o    = imm_j_type;
                rd_wen_o = 1'b1;
                jal_o    = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* source/core_ibuf.sv */
module core_ibuf import core_pkg::*; (
    input  logic            clock,
    input  logic            rst_n_i,
    input  logic            flush_i,
    input  logic            push_valid_i,
    input  logic [31:0]     push_inst_i,
    input  logic [31:0]     push_pc_i,
    input  logic            pop_i,
    output logic            push_ready_o,
    output logic            head_valid_o,
    output logic [31:0]     head_inst_o,
    output logic [31:0]     head_pc_o
);

    logic [XLEN-1:0]       inst_mem [IBUF_DEPTH];
    logic [XLEN-1:0]       pc_mem   [IBUF_DEPTH];
    logic [IBUF_PTR_W-1:0] wr_ptr_q;
    logic [IBUF_PTR_W-1:0] rd_ptr_q;
    logic [IBUF_PTR_W:0]   count_q;
    logic                  push_fire;
    logic                  pop_fire;

    assign push_ready_o = (count_q < IBUF_DEPTH);
    assign head_valid_o = (count_q != '0);
    assign head_inst_o  = inst_mem[rd_ptr_q];
    assign head_pc_o    = pc_mem[rd_ptr_q];

    // a push in the flush cycle belongs to the old path
    assign push_fire = push_valid_i && push_ready_o && !flush_i;
    assign pop_fire  = pop_i && head_valid_o;

    always_ff @(posedge clock) begin
        if (push_fire) begin
            inst_mem[wr_ptr_q] <= push_inst_i;
            pc_mem[wr_ptr_q]   <= push_pc_i;
        end
    end

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_fire) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_fire) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (push_fire && !pop_fire) begin
                count_q <= count_q + 1'b1;
            end else if (pop_fire && !push_fire) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    a_no_pop_empty: assert property (@(posedge clock) disable iff (!rst_n_i)
        pop_i |-> head_valid_o);

    a_count_max: assert property (@(posedge clock) disable iff (!rst_n_i)
        count_q <= IBUF_DEPTH);

endmodule

/* source/core_ifu.sv */
module core_ifu import core_pkg::*; (
    input  logic            clock,
    input  logic            rst_n_i,
    input  logic            m_arready_i,
    input  logic            m_rvalid_i,
    input  logic [31:0]     m_rdata_i,
    input  logic            push_ready_i,
    input  logic            redirect_valid_i,
    input  logic [31:0]     redirect_pc_i,
    output logic            m_arvalid_o,
    output logic [31:0]     m_araddr_o,
    output logic [2:0]      m_arprot_o,
    output logic            m_rready_o,
    output logic            push_valid_o,
    output logic [31:0]     push_inst_o,
    output logic [31:0]     push_pc_o
);

    ifu_state_e      state_q;
    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_inc;
    logic [XLEN-1:0] araddr_q;
    logic [XLEN-1:0] inst_q;
    logic            arvalid_q;
    logic            drop_q;
    logic            ar_fire;
    logic            r_fire;
    logic            push_fire;

    assign pc_inc    = pc_q + 32'd4;
    assign ar_fire   = arvalid_q && m_arready_i;
    assign r_fire    = (state_q == IFU_DATA) && m_rvalid_i;
    assign push_fire = push_valid_o && push_ready_i;

    assign m_arvalid_o = arvalid_q;
    assign m_araddr_o  = araddr_q;
    // instruction access, secure, unprivileged
    assign m_arprot_o  = 3'b100;
    assign m_rready_o  = (state_q == IFU_DATA);

    // word goes straight from R into the queue when there is room
    assign push_valid_o = (state_q == IFU_PUSH) || (r_fire && !drop_q);
    assign push_inst_o  = (state_q == IFU_PUSH) ? inst_q : m_rdata_i;
    assign push_pc_o    = pc_q;

    always_ff @(posedge clock or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q   <= IFU_ADDR;
            pc_q      <= RESET_PC;
            araddr_q  <= RESET_PC;
            arvalid_q <= 1'b0;
            drop_q    <= 1'b0;
        end else begin
            case (state_q)
                IFU_ADDR: begin
                    if (!arvalid_q) begin
                        arvalid_q <= 1'b1;
                        araddr_q  <= redirect_valid_i ? redirect_pc_i : pc_q;
                        if (redirect_valid_i) begin
                            pc_q <= redirect_pc_i;
                        end
                    end else begin
                        // AR already raised, its beat will be stale
                        if (redirect_valid_i) begin
                            pc_q   <= redirect_pc_i;
                            drop_q <= 1'b1;
                        end
                        if (ar_fire) begin
                            arvalid_q <= 1'b0;
                            state_q   <= IFU_DATA;
                        end
                    end
                end
                IFU_DATA: begin
                    if (redirect_valid_i) begin
                        pc_q <= redirect_pc_i;
                    end
                    if (m_rvalid_i) begin
                        state_q   <= IFU_ADDR;
                        arvalid_q <= 1'b1;
                        if (redirect_valid_i) begin
                            drop_q   <= 1'b0;
                            araddr_q <= redirect_pc_i;
                        end else if (drop_q) begin
                            drop_q   <= 1'b0;
                            araddr_q <= pc_q;
                        end else if (push_fire) begin
                            pc_q     <= pc_inc;
                            araddr_q <= pc_inc;
                        end else begin
                            inst_q    <= m_rdata_i;
                            arvalid_q <= 1'b0;
                            state_q   <= IFU_PUSH;
                        end
                    end else if (redirect_valid_i) begin
                        drop_q <= 1'b1;
                    end
                end
                IFU_PUSH: begin
                    if (redirect_valid_i) begin
                        pc_q      <= redirect_pc_i;
                        araddr_q  <= redirect_pc_i;
                        arvalid_q <= 1'b1;
                        state_q   <= IFU_ADDR;
                    end else if (push_ready_i) begin
                        pc_q      <= pc_inc;
                        araddr_q  <= pc_inc;
                        arvalid_q <= 1'b1;
                        state_q   <= IFU_ADDR;
                    end
                end
                default: state_q <= IFU_ADDR;
            endcase
        end
    end

    a_ar_stable: assert property (@(posedge clock) disable iff (!rst_n_i)
        m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o));

    a_ar_align: assert property (@(posedge clock) disable iff (!rst_n_i)
        m_arvalid_o |-> m_araddr_o[1:0] == 2'b00);

endmodule

/* source/core_pkg.sv */
package core_pkg;

    localparam int XLEN = 32;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // instruction queue, depth kept a power of two so pointers wrap freely
    localparam int IBUF_DEPTH = 4;
    localparam int IBUF_PTR_W = $clog2(IBUF_DEPTH);

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B
    } alu_op_e;

    // IFU_ADDR  AR pending
    // IFU_DATA  waiting on the R beat
    // IFU_PUSH  word held until the queue has room
    typedef enum logic [1:0] {
        IFU_ADDR,
        IFU_DATA,
        IFU_PUSH
    } ifu_state_e;

endpackage
